// ==== sim.f ====
n163_pkg.sv
n163_bank_regs.sv
n163_prg_map.sv
n163_chr_map.sv
n163_irq_timer.sv
n163_mapper.sv
tb_n163.sv

// ==== Bender.yml ====
package:
  name: n163_mapper

sources:
  - n163_pkg.sv
  - n163_bank_regs.sv
  - n163_prg_map.sv
  - n163_chr_map.sv
  - n163_irq_timer.sv
  - n163_mapper.sv
  - target: test
    files:
      - tb_n163.sv

// ==== tb_n163.sv ====
// N163 mapper testbench walking a table of bus cycles against expected results
module tb_n163;
	timeunit 1ns;
	timeprecision 100ps;
	import n163_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam prg_bank_t PRG_MASK = '1;
	localparam chr_bank_t CHR_MASK = '1;
	localparam logic [1:0] OP_CPU = 2'd0;
	localparam logic [1:0] OP_PPU = 2'd1;
	localparam logic [1:0] OP_WAIT = 2'd2; // poll irq until it matches
	localparam logic [1:0] OP_HOLD = 2'd3; // irq must keep its level

	typedef struct packed {
		logic [2:0]  grp;
		logic [1:0]  op;
		logic [15:0] addr;   // cpu address, or ppu address for OP_PPU
		logic [7:0]  data;
		logic        wr;
		logic        chk_a;
		logic        chk_d;
		logic [18:0] exp_a;
		logic [7:0]  exp_d;
		logic [2:0]  exp_f;  // per op flags, see the run tasks
		logic [8:0]  clocks; // irq ops only
	} entry_t;

	logic clk20 = 1'b0;
	logic reset;
	logic ce;
	cpu_addr_t prg_ain;
	data_t prg_din;
	logic prg_write;
	ppu_addr_t chr_ain;
	logic chr_read;
	logic chr_write;
	prg_out_t prg_aout;
	data_t prg_dout;
	logic prg_oe;
	logic prg_allow;
	chr_out_t chr_aout;
	logic chr_ram_oe;
	logic chr_ram_we;
	logic vram_ce;
	logic vram_a10;
	logic irq;

	entry_t steps [0:127];
	int n_entries = 0;
	int errors = 0;
	int grp_err = 0;
	int checks = 0;
	int tests = 0;
	logic [31:0] lfsr = 32'hf39d_0cb9;

	// reference model of the mapper state while the table is built
	prg_bank_t m_prg89;
	prg_bank_t m_prg_ab;
	prg_bank_t m_prg_cd;
	chr_bank_t m_chr [12];
	logic [1:0] m_en;
	irq_count_t m_cnt;

	n163_mapper #(.PRG_BANK_MASK(PRG_MASK), .CHR_BANK_MASK(CHR_MASK)) n163_mapper_i (.*);

	always #(CLK_PERIOD / 2) clk20 = ~clk20;

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic string group_name(input int g);
		case (g)
			1: return "prg mapping";
			2: return "work ram";
			3: return "chr pattern banks";
			4: return "nametables";
			default: return "irq timer";
		endcase
	endfunction

	task automatic add_cpu(input int grp, input cpu_addr_t a, input data_t d, input logic wr);
		entry_t e;
		logic ram;
		logic reg_page;
		prg_bank_t bank;
		e = '0;
		ram = a[15:13] == 3'b011;
		reg_page = a[15:12] == 4'h5;
		case (a[14:13])
			2'd0: bank = m_prg89;
			2'd1: bank = m_prg_ab;
			2'd2: bank = m_prg_cd;
			default: bank = '1; // top slot is fixed
		endcase
		e.grp = 3'(grp);
		e.op = OP_CPU;
		e.addr = a;
		e.data = d;
		e.wr = wr;
		e.exp_a = ram ? {6'd0, a[12:0]} : {bank & PRG_MASK, a[12:0]};
		e.chk_a = a[15] || ram;
		e.chk_d = !wr && reg_page;
		e.exp_d = a[11] ? m_cnt[15:8] : m_cnt[7:0];
		e.exp_f = {1'b0, !wr && (a[15] || ram || reg_page), (a[15] && !wr) || ram};
		steps[n_entries] = e;
		n_entries++;
		if (wr && a[15] && a[14:11] < 4'd12) m_chr[a[14:11]] = d;
		if (wr && a[15:11] == 5'b11100) m_prg89 = d[5:0];
		if (wr && a[15:11] == 5'b11101) begin
			m_prg_ab = d[5:0];
			m_en = d[7:6];
		end
		if (wr && a[15:11] == 5'b11110) m_prg_cd = d[5:0];
		// counter steps on every ce unless a byte is written
		if (m_cnt[15] && m_cnt[14:0] != 15'h7fff) m_cnt = m_cnt + 1'b1;
		if (wr && a[15:11] == 5'b01010) m_cnt[7:0] = d;
		if (wr && a[15:11] == 5'b01011) m_cnt[15:8] = d;
	endtask

	task automatic add_ppu(input int grp, input ppu_addr_t a, input logic wr);
		entry_t e;
		chr_bank_t bank;
		logic high;
		logic vce;
		e = '0;
		bank = a[13] ? m_chr[8 + a[11:10]] : m_chr[a[12:10]];
		high = bank >= 8'he0;
		vce = a[13] && high;
		e.grp = 3'(grp);
		e.op = OP_PPU;
		e.addr = {2'b00, a};
		e.wr = wr;
		e.exp_a = {1'b0, bank & CHR_MASK, a[9:0]};
		e.chk_a = !vce;
		e.exp_f = {bank[0], vce, wr && high && !m_en[a[12]] && !a[13]};
		steps[n_entries] = e;
		n_entries++;
	endtask

	task automatic add_irq(input logic [1:0] op, input cpu_addr_t a, input int clocks,
			input logic level);
		entry_t e;
		e = '0;
		e.grp = 3'd5;
		e.op = op;
		e.addr = a;
		e.clocks = 9'(clocks);
		e.exp_f = {2'b00, level};
		steps[n_entries] = e;
		n_entries++;
	endtask

	task automatic build_table();
		data_t d;
		m_prg89 = '0;
		m_prg_ab = '0;
		m_prg_cd = '0;
		m_en = '0;
		m_cnt = '0;
		for (int i = 0; i < 12; i++) m_chr[i] = '0;
		add_cpu(1, 16'he000, 8'(rand_bits(8)), 1'b1);
		add_cpu(1, 16'he800, 8'(rand_bits(8)), 1'b1);
		add_cpu(1, 16'hf000, 8'(rand_bits(8)), 1'b1);
		for (int s = 0; s < 4; s++) add_cpu(1, {1'b1, 2'(s), 13'(rand_bits(13))}, 8'h00, 1'b0);
		add_cpu(1, 16'h8000, 8'(rand_bits(8)), 1'b1); // write cycle, no prg_allow
		for (int k = 0; k < 4; k++) begin
			add_cpu(2, {3'b011, 13'(rand_bits(13))}, 8'(rand_bits(8)), k[0]);
		end
		for (int i = 0; i < 8; i++) begin
			d = 8'(rand_bits(8));
			if (i == 2 || i == 6) d = d | 8'he0; // one RAM bank per pattern half
			add_cpu(3, {5'(16 + i), 11'h000}, d, 1'b1);
		end
		add_cpu(3, 16'he800, {2'b10, 6'(rand_bits(6))}, 1'b1); // RAM off in the upper half
		for (int i = 0; i < 8; i++) add_ppu(3, {1'b0, 3'(i), 10'(rand_bits(10))}, 1'b1);
		for (int i = 0; i < 4; i++) begin
			d = 8'(rand_bits(8));
			d = i[0] ? {3'b111, d[4:1], i[1]} : (d & 8'h7f); // both CIRAM pages used
			add_cpu(4, {5'(24 + i), 11'h000}, d, 1'b1);
		end
		for (int i = 0; i < 8; i++) add_ppu(4, {1'b1, 3'(i), 10'(rand_bits(10))}, i[1]);
		add_cpu(5, 16'h5000, 8'hf0, 1'b1);
		add_cpu(5, 16'h5800, 8'hff, 1'b1);
		add_cpu(5, 16'h5800, 8'h00, 1'b0);
		add_cpu(5, 16'h5000, 8'h00, 1'b0);
		add_irq(OP_WAIT, 16'h0000, 80, 1'b1); // 20 ce strobes
		add_irq(OP_HOLD, 16'h0000, 32, 1'b1);
		add_irq(OP_WAIT, 16'h5000, 2, 1'b0);  // acknowledge
		m_cnt = 16'hffff;                      // saturated by now
		add_cpu(5, 16'h5800, 8'h7f, 1'b1);
		add_cpu(5, 16'h5000, 8'h00, 1'b0);
		add_irq(OP_HOLD, 16'h0000, 256, 1'b0); // 64 ce, counter stopped
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			grp_err++;
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// ce low again, then two idle clocks so ce comes one clock in four
	task automatic finish_cycle();
		@(posedge clk20);
		#1;
		ce = 1'b0;
		prg_write = 1'b0;
		prg_ain = '0;
		chr_write = 1'b0;
		chr_read = 1'b0;
		repeat (2) @(posedge clk20);
	endtask

	task automatic run_cpu(input entry_t e);
		@(posedge clk20);
		#1;
		prg_ain = e.addr;
		prg_din = e.data;
		prg_write = e.wr;
		ce = 1'b1;
		#3;
		if (e.chk_a) compare_value("prg_aout", prg_aout, e.exp_a);
		compare_value("prg_oe", prg_oe, e.exp_f[1]);
		compare_value("prg_allow", prg_allow, e.exp_f[0]);
		if (e.chk_d) compare_value("prg_dout", prg_dout, e.exp_d);
		finish_cycle();
	endtask

	task automatic run_ppu(input entry_t e);
		@(posedge clk20);
		#1;
		chr_ain = e.addr[13:0];
		chr_write = e.wr;
		chr_read = !e.wr;
		ce = 1'b1;
		#3;
		if (e.chk_a) compare_value("chr_aout", chr_aout, e.exp_a[17:0]);
		compare_value("chr_ram_we", chr_ram_we, e.exp_f[0]);
		compare_value("chr_ram_oe", chr_ram_oe, !e.wr && !e.exp_f[1]); // reads outside CIRAM
		compare_value("vram_ce", vram_ce, e.exp_f[1]);
		if (e.exp_f[1]) compare_value("vram_a10", vram_a10, e.exp_f[2]);
		finish_cycle();
	endtask

	task automatic run_irq(input entry_t e);
		int n;
		logic seen;
		logic broke;
		n = 0;
		seen = 1'b0;
		broke = 1'b0;
		while (n < e.clocks && !(seen && e.op == OP_WAIT)) begin
			@(posedge clk20);
			#1;
			prg_ain = e.addr;
			ce = (n % 4 == 0);
			#3;
			if (irq === e.exp_f[0]) seen = 1'b1;
			else broke = 1'b1;
			n++;
		end
		checks++;
		if ((e.op == OP_WAIT && !seen) || (e.op == OP_HOLD && broke)) begin
			errors++;
			grp_err++;
			if (e.op == OP_WAIT) $display("irq never reached %b within %0d clocks at %0t ns",
				e.exp_f[0], e.clocks, $time);
			else $display("irq left %b during a %0d clock idle stretch at %0t ns",
				e.exp_f[0], e.clocks, $time);
		end
		finish_cycle();
	endtask

	initial begin
		reset = 1'b1;
		ce = 1'b0;
		prg_ain = '0;
		prg_din = '0;
		prg_write = 1'b0;
		chr_ain = '0;
		chr_read = 1'b0;
		chr_write = 1'b0;
		build_table();
		repeat (5) @(posedge clk20);
		#1;
		reset = 1'b0;
		for (int i = 0; i < n_entries; i++) begin
			case (steps[i].op)
				OP_CPU: run_cpu(steps[i]);
				OP_PPU: run_ppu(steps[i]);
				default: run_irq(steps[i]);
			endcase
			if (i == n_entries - 1 || steps[i + 1].grp != steps[i].grp) begin
				tests++;
				$display("test %0d %s finished with %0d errors", steps[i].grp,
					group_name(steps[i].grp), grp_err);
				grp_err = 0;
			end
		end
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// budget of 64 clocks per table entry plus reset
	initial begin
		wait (n_entries > 0);
		#((n_entries * 64 + 16) * CLK_PERIOD);
		$display("timeout, the table did not complete in %0d clocks", n_entries * 64 + 16);
		$display("Something failed");
		$finish;
	end

endmodule

// ==== n163_mapper.sv ====
// N163 mapper core joining bank registers, PRG and CHR translation and the IRQ timer
module n163_mapper #(
	parameter n163_pkg::prg_bank_t PRG_BANK_MASK = '1,
	parameter n163_pkg::chr_bank_t CHR_BANK_MASK = '1
) (
	input  logic                clk20,
	input  logic                reset,
	input  logic                ce,         // one clock per CPU cycle
	input  n163_pkg::cpu_addr_t prg_ain,
	input  n163_pkg::data_t     prg_din,
	input  logic                prg_write,
	input  n163_pkg::ppu_addr_t chr_ain,
	input  logic                chr_read,
	input  logic                chr_write,
	output n163_pkg::prg_out_t  prg_aout,
	output n163_pkg::data_t     prg_dout,
	output logic                prg_oe,
	output logic                prg_allow,
	output n163_pkg::chr_out_t  chr_aout,
	output logic                chr_ram_oe,
	output logic                chr_ram_we,
	output logic                vram_ce,
	output logic                vram_a10,
	output logic                irq
);
	import n163_pkg::*;

	prg_bank_t  prg_bank89;
	prg_bank_t  prg_bank_ab;
	prg_bank_t  prg_bank_cd;
	chr_bank_t  chr_bank [12];
	logic [1:0] chr_ram_en;
	logic       prg_is_ram;
	logic       mem_oe;
	data_t      reg_dout;  // IRQ counter readback
	logic       reg_oe;

	n163_bank_regs bank_regs_i (
		.clk20       (clk20),
		.reset       (reset),
		.ce          (ce),
		.prg_write   (prg_write),
		.prg_ain     (prg_ain),
		.prg_din     (prg_din),
		.prg_bank89  (prg_bank89),
		.prg_bank_ab (prg_bank_ab),
		.prg_bank_cd (prg_bank_cd),
		.chr_bank    (chr_bank),
		.chr_ram_en  (chr_ram_en)
	);

	n163_prg_map #(.PRG_BANK_MASK(PRG_BANK_MASK)) prg_map_i (
		.prg_ain     (prg_ain),
		.prg_write   (prg_write),
		.prg_bank89  (prg_bank89),
		.prg_bank_ab (prg_bank_ab),
		.prg_bank_cd (prg_bank_cd),
		.prg_aout    (prg_aout),
		.prg_is_ram  (prg_is_ram),
		.mem_oe      (mem_oe)
	);

	n163_chr_map #(.CHR_BANK_MASK(CHR_BANK_MASK)) chr_map_i (
		.chr_ain    (chr_ain),
		.chr_read   (chr_read),
		.chr_write  (chr_write),
		.chr_bank   (chr_bank),
		.chr_ram_en (chr_ram_en),
		.chr_aout   (chr_aout),
		.chr_ram_oe (chr_ram_oe),
		.chr_ram_we (chr_ram_we),
		.vram_ce    (vram_ce),
		.vram_a10   (vram_a10)
	);

	n163_irq_timer irq_timer_i (
		.clk20     (clk20),
		.reset     (reset),
		.ce        (ce),
		.prg_write (prg_write),
		.prg_ain   (prg_ain),
		.prg_din   (prg_din),
		.irq       (irq),
		.reg_dout  (reg_dout),
		.reg_oe    (reg_oe)
	);

	assign prg_oe    = reg_oe || mem_oe;
	assign prg_dout  = reg_oe ? reg_dout : prg_din; // register reads override the bus
	assign prg_allow = (prg_ain[15] && !prg_write) || prg_is_ram; // ROM reads, RAM both ways

endmodule

// ==== n163_irq_timer.sv ====
// N163 IRQ timer with a readable 15 bit up counter acknowledged at $5000 to $5FFF
module n163_irq_timer (
	input  logic                clk20,
	input  logic                reset,
	input  logic                ce,
	input  logic                prg_write,
	input  n163_pkg::cpu_addr_t prg_ain,
	input  n163_pkg::data_t     prg_din,
	output logic                irq,
	output n163_pkg::data_t     reg_dout,
	output logic                reg_oe
);
	import n163_pkg::*;

	irq_count_t count;
	irq_count_t count_next;
	logic       count_en;
	logic       page_lo;
	logic       page_hi;
	logic       irq_page;

	assign page_lo  = prg_ain[15:11] == PAGE_IRQ_LO;
	assign page_hi  = prg_ain[15:11] == PAGE_IRQ_HI;
	assign irq_page = page_lo || page_hi;  // whole $5000 to $5fff

	assign count_next = count + 1'b1;
	assign count_en   = count[15] && !(&count[14:0]); // stops at $ffff

	always_ff @(posedge clk20) begin
		if (reset) begin
			count <= '0;
			irq   <= 1'b0;
		end else if (ce) begin
			// any access here acknowledges, ahead of a new timeout
			if (irq_page) begin
				irq <= 1'b0;
			end else if (&count) begin
				irq <= 1'b1;
			end

			if (prg_write && page_lo) begin
				count[7:0] <= prg_din;
			end else if (count_en) begin
				count[7:0] <= count_next[7:0];
			end

			if (prg_write && page_hi) begin
				count[15:8] <= prg_din;
			end else if (count_en) begin
				count[15:8] <= count_next[15:8];
			end
		end
	end

	assign reg_dout = page_hi ? count[15:8] : count[7:0];
	assign reg_oe   = !prg_write && irq_page;

	// a new irq needs a ce with the counter saturated just before
	irq_cause: assert property (
		@(posedge clk20) disable iff (reset)
		$rose(irq) |-> $past(ce && (&count))
	) else $error("irq rose without the counter at all ones");

endmodule

// ==== n163_chr_map.sv ====
// N163 CHR translator steering PPU accesses to CHR ROM, CHR RAM or CIRAM
module n163_chr_map #(
	parameter n163_pkg::chr_bank_t CHR_BANK_MASK = '1
) (
	input  n163_pkg::ppu_addr_t chr_ain,
	input  logic                chr_read,
	input  logic                chr_write,
	input  n163_pkg::chr_bank_t chr_bank [12],
	input  logic [1:0]          chr_ram_en,
	output n163_pkg::chr_out_t  chr_aout,
	output logic                chr_ram_oe,
	output logic                chr_ram_we,
	output logic                vram_ce,
	output logic                vram_a10
);
	import n163_pkg::*;

	logic [3:0] slot;      // 1 KB window of the PPU map
	chr_bank_t  sel_bank;
	logic       high_bank; // $e0 and up
	logic       chr_ram;
	logic       name_half;

	assign slot      = chr_ain[13:10];
	assign name_half = chr_ain[13];

	// nametable windows $2000 and $3000 share registers 8 to 11
	always_comb begin
		if (slot[3]) begin
			sel_bank = chr_bank[{2'b10, slot[1:0]}];
		end else begin
			sel_bank = chr_bank[slot[2:0]];
		end
	end

	assign high_bank = sel_bank >= CIRAM_BANK_MIN;

	// enable bit picked by a12, set bit keeps the bank in ROM
	assign chr_ram = high_bank && !name_half && !chr_ram_en[chr_ain[12]]; // pattern half only

	always_comb begin
		if (name_half) begin
			vram_ce    = high_bank; // console nametable RAM
			chr_ram_oe = !high_bank && chr_read;
		end else begin
			vram_ce    = 1'b0;
			chr_ram_oe = chr_read;
		end
	end

	assign chr_ram_we = chr_write && chr_ram;

	assign vram_a10 = sel_bank[0];   // picks one of the two CIRAM pages
	assign chr_aout = {sel_bank & CHR_BANK_MASK, chr_ain[9:0]};

	// CIRAM and cartridge RAM never written on the same access
	no_double_write: assert final (!(vram_ce && chr_ram_we))
		else $error("vram_ce and chr_ram_we high together");

endmodule

// ==== n163_prg_map.sv ====
// N163 PRG translator mapping CPU addresses onto PRG ROM and work RAM
module n163_prg_map #(
	parameter n163_pkg::prg_bank_t PRG_BANK_MASK = '1
) (
	input  n163_pkg::cpu_addr_t prg_ain,
	input  logic                prg_write,
	input  n163_pkg::prg_bank_t prg_bank89,
	input  n163_pkg::prg_bank_t prg_bank_ab,
	input  n163_pkg::prg_bank_t prg_bank_cd,
	output n163_pkg::prg_out_t  prg_aout,
	output logic                prg_is_ram,
	output logic                mem_oe
);
	import n163_pkg::*;

	prg_bank_t slot_bank;  // bank for the 8 KB slot
	prg_bank_t rom_bank;
	logic      rom_sel;

	// slot chosen by a14:a13 within $8000 to $ffff
	always_comb begin
		case (prg_ain[14:13])
			2'd0: slot_bank = prg_bank89;
			2'd1: slot_bank = prg_bank_ab;
			2'd2: slot_bank = prg_bank_cd;
			default: slot_bank = PRG_FIXED_BANK;
		endcase
	end

	assign rom_bank   = slot_bank & PRG_BANK_MASK; // wrap to the ROM size
	assign rom_sel    = prg_ain[15];
	assign prg_is_ram = prg_ain[15:13] == 3'b011;  // $6000 to $7fff

	always_comb begin
		if (prg_is_ram) begin
			prg_aout = {WRAM_BANK, prg_ain[12:0]};
		end else begin
			prg_aout = {rom_bank, prg_ain[12:0]};
		end
	end

	// memory drives the data bus on reads only
	assign mem_oe = !prg_write && (rom_sel || prg_is_ram);

endmodule

// ==== n163_bank_regs.sv ====
// N163 bank register file loaded by CPU writes in the $8000 to $F7FF window
module n163_bank_regs (
	input  logic                clk20,
	input  logic                reset,
	input  logic                ce,
	input  logic                prg_write,
	input  n163_pkg::cpu_addr_t prg_ain,
	input  n163_pkg::data_t     prg_din,
	output n163_pkg::prg_bank_t prg_bank89,
	output n163_pkg::prg_bank_t prg_bank_ab,
	output n163_pkg::prg_bank_t prg_bank_cd,
	output n163_pkg::chr_bank_t chr_bank [12],
	output logic [1:0]          chr_ram_en
);
	import n163_pkg::*;

	localparam int CHR_REGS = 12;

	logic [4:0] page;   // 2 KB write page
	logic       wr_en;
	logic [CHR_REGS*$bits(chr_bank_t)-1:0] chr_flat;

	assign page  = prg_ain[15:11];
	assign wr_en = ce && prg_write;

	always_ff @(posedge clk20) begin
		if (reset) begin
			for (int i = 0; i < CHR_REGS; i++) begin
				chr_bank[i] <= '0;
			end
			prg_bank89  <= '0;
			prg_bank_ab <= '0;
			prg_bank_cd <= '0;
			chr_ram_en  <= '0;
		end else if (wr_en) begin
			// $8000 to $dfff, one CHR register per 2 KB page
			for (int i = 0; i < CHR_REGS; i++) begin
				if (page == PAGE_CHR0 + 5'(i)) begin
					chr_bank[i] <= prg_din;
				end
			end
			case (page)
				PAGE_PRG89: prg_bank89 <= prg_din[5:0]; // top bits belong to sound/mirroring
				PAGE_CHRAB: begin
					prg_bank_ab <= prg_din[5:0];
					chr_ram_en  <= prg_din[7:6]; // 1 disables CHR RAM in that half
				end
				PAGE_PRGCD: prg_bank_cd <= prg_din[5:0];
				default: ;
			endcase
		end
	end

	// flat copy of the CHR registers for the hold check
	always_comb begin
		for (int i = 0; i < CHR_REGS; i++) begin
			chr_flat[i*$bits(chr_bank_t) +: $bits(chr_bank_t)] = chr_bank[i];
		end
	end

	// nothing moves between qualified CPU writes
	regs_hold: assert property (
		@(posedge clk20) disable iff (reset)
		!wr_en |=> $stable({prg_bank89, prg_bank_ab, prg_bank_cd, chr_ram_en, chr_flat})
	) else $error("bank register changed without a CPU write");

endmodule

// ==== n163_pkg.sv ====
// N163 mapper package with bus widths, bank types and register page numbers
package n163_pkg;

	// CPU and PPU side buses
	typedef logic [15:0] cpu_addr_t;
	typedef logic [13:0] ppu_addr_t;
	typedef logic [7:0]  data_t;

	// bank numbers as held in the register file
	typedef logic [5:0]  prg_bank_t; // 8 KB units
	typedef logic [7:0]  chr_bank_t; // 1 KB units

	// translated addresses toward the cartridge memories
	typedef logic [18:0] prg_out_t;  // bank plus 13 bit offset
	typedef logic [17:0] chr_out_t;  // bank plus 10 bit offset

	typedef logic [15:0] irq_count_t; // bit 15 enables counting

	// write pages, decoded from cpu address bits 15:11
	// first of twelve CHR bank pages
	localparam logic [4:0] PAGE_CHR0   = 5'b10000; // $8000
	localparam logic [4:0] PAGE_PRG89  = 5'b11100; // $e000
	localparam logic [4:0] PAGE_CHRAB  = 5'b11101; // $e800
	localparam logic [4:0] PAGE_PRGCD  = 5'b11110; // $f000

	// IRQ counter bytes, readable as well as writable
	localparam logic [4:0] PAGE_IRQ_LO = 5'b01010; // $5000
	localparam logic [4:0] PAGE_IRQ_HI = 5'b01011; // $5800

	// last 8 KB of the CPU map always sees the top bank
	localparam prg_bank_t PRG_FIXED_BANK = 6'b111111;

	// PRG bus bank used for the 8 KB work RAM at $6000
	localparam prg_bank_t WRAM_BANK = 6'b000000;

	// banks $e0 and above pick CIRAM or CHR RAM instead of ROM
	localparam chr_bank_t CIRAM_BANK_MIN = 8'he0;

endpackage
